//--- Makefile
VERILATOR ?= verilator
TOP       := pipeCpuTb
RTLTOP    := pipeCpu
FILELIST  := pipeCpu.f
LINTFLAGS := --lint-only -Wall --timing
SIMFLAGS  := --binary --timing --assert
BUILDDIR  := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- bench/pipeCpuTb.sv
/* testbench for the pipelined core: memory model, instruction encoders,
   directed tests, compare tasks and result counters */
`timescale 1ns/1ns
`default_nettype none

module pipeCpuTb;

  logic CLK;
  logic nRST;
  logic imemREN;
  cpuTypesPkg::wordT imemaddr;
  cpuTypesPkg::wordT imemload;
  logic ihit;
  logic dmemREN;
  logic dmemWEN;
  cpuTypesPkg::wordT dmemaddr;
  cpuTypesPkg::wordT dmemstore;
  cpuTypesPkg::wordT dmemload;
  logic dhit;
  logic halt;

  cpuTypesPkg::wordT imem [256];  // word addressed
  cpuTypesPkg::wordT dmem [256];
  int progLen;
  bit randomWaits;                // random dhit latency
  bit accessBusy;
  int waitLeft;
  int storeCount;
  logic [31:0] rngState;

  int errors;
  int errorsAtStart;
  int testsRun;
  int testsFailed;
  string testName;

  pipeCpu #(.pcInit(32'h0)) u_pipeCpu (
    .CLK, .nRST, .imemREN, .imemaddr, .imemload, .ihit,
    .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .dmemload, .dhit, .halt
  );

  always #2 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory side, everything moves on the falling edge
  always @(negedge CLK) begin
    imemload = imem[imemaddr[9:2]];
    if (!nRST) begin
      dhit = 1'b0;
      accessBusy = 1'b0;
    end else if (dhit) begin
      dhit = 1'b0;                // one cycle pulse
    end else if (dmemREN || dmemWEN) begin
      if (!accessBusy) begin
        accessBusy = 1'b1;
        waitLeft = 0;
        if (randomWaits) begin
          rngState = xorshift(rngState);
          waitLeft = int'(rngState % 32'd4);
        end
      end
      if (waitLeft == 0) begin
        accessBusy = 1'b0;
        dhit = 1'b1;
        if (dmemWEN) begin
          dmem[dmemaddr[9:2]] = dmemstore;
          storeCount++;
        end else begin
          dmemload = dmem[dmemaddr[9:2]];
        end
      end else begin
        waitLeft--;
      end
    end
  end

  function automatic cpuTypesPkg::wordT rInstr(input logic [5:0] funct, input int rs,
                                               input int rt, input int rd, input int shamt);
    return {6'b000000, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
  endfunction

  function automatic cpuTypesPkg::wordT iInstr(input logic [5:0] op, input int rs,
                                               input int rt, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic cpuTypesPkg::wordT jInstr(input logic [5:0] op, input int target);
    return {op, target[25:0]};
  endfunction

  function automatic cpuTypesPkg::wordT signExt(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // data fill, distinct for every word address
  function automatic cpuTypesPkg::wordT fillWord(input int idx);
    return 32'hD000_0000 | cpuTypesPkg::wordT'(idx << 2);
  endfunction

  task automatic clearProgram();
    progLen = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = cpuTypesPkg::haltWord;  // runaway fetch stops
    end
  endtask

  task automatic addInstr(input cpuTypesPkg::wordT instr);
    imem[progLen] = instr;
    progLen++;
  endtask

  task automatic clearData();
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fillWord(i);
    end
    storeCount = 0;
  endtask

  task automatic checkWord(input string name, input cpuTypesPkg::wordT expected,
                           input cpuTypesPkg::wordT actual);
    if (actual !== expected) begin
      $display("Fail %s: expected 0x%08h, got 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkStored(input int addr, input cpuTypesPkg::wordT expected);
    checkWord($sformatf("dmem[0x%03h]", addr), expected, dmem[addr[9:2]]);
  endtask

  task automatic startTest(input string name);
    testName = name;
    errorsAtStart = errors;
    testsRun++;
  endtask

  task automatic finishTest();
    if (errors == errorsAtStart) begin
      $display("test %s: ok", testName);
    end else begin
      testsFailed++;
      $display("test %s: failed with %0d errors", testName, errors - errorsAtStart);
    end
  endtask

  task automatic applyReset();
    @(negedge CLK);
    nRST = 1'b0;
    repeat (5) @(negedge CLK);
    nRST = 1'b1;
  endtask

  task automatic waitForHalt(input int limit);
    int cycles;
    cycles = 0;
    while (halt !== 1'b1 && cycles < limit) begin
      @(negedge CLK);
      cycles++;
    end
    if (halt !== 1'b1) begin
      $display("halt was not raised within %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic runProgram(input int limit);
    applyReset();
    waitForHalt(limit);
  endtask

  task automatic resetTest();
    startTest("reset");
    clearProgram();
    clearData();
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 1, 'h1));
    addInstr(cpuTypesPkg::haltWord);
    applyReset();
    checkBit("halt", 1'b0, halt);
    checkBit("dmemREN", 1'b0, dmemREN);
    checkBit("dmemWEN", 1'b0, dmemWEN);
    checkBit("imemREN", 1'b1, imemREN);
    checkWord("imemaddr", 32'h0, imemaddr);
    @(negedge CLK);               // first advancing edge
    checkWord("imemaddr", 32'h4, imemaddr);
    waitForHalt(100);
    finishTest();
  endtask

  // dependent chain, every result stored at 0x100 + 4k
  task automatic aluChainTest(input string name, input bit randomMode);
    cpuTypesPkg::wordT r [15];
    int k;
    startTest(name);
    randomWaits = randomMode;
    clearProgram();
    clearData();
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 1, 'h1234));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 1, 2, -3));
    addInstr(rInstr(cpuTypesPkg::ADDU, 1, 2, 3, 0));
    addInstr(rInstr(cpuTypesPkg::SUBU, 2, 3, 4, 0));
    addInstr(rInstr(cpuTypesPkg::AND, 4, 3, 5, 0));
    addInstr(rInstr(cpuTypesPkg::OR, 5, 1, 6, 0));
    addInstr(rInstr(cpuTypesPkg::XOR, 6, 4, 7, 0));
    addInstr(rInstr(cpuTypesPkg::SLT, 4, 1, 8, 0));
    addInstr(rInstr(cpuTypesPkg::SLT, 1, 4, 9, 0));
    addInstr(rInstr(cpuTypesPkg::SLL, 0, 8, 10, 5));
    addInstr(iInstr(cpuTypesPkg::ORI, 10, 11, 'h8001));
    addInstr(iInstr(cpuTypesPkg::ANDI, 4, 12, 'hF0F0));
    addInstr(iInstr(cpuTypesPkg::LUI, 0, 13, 'hBEEF));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 13, 14, 'h7FFF));
    for (k = 1; k < 15; k++) begin
      addInstr(iInstr(cpuTypesPkg::SW, 0, k, 'h100 + 4 * k));
    end
    addInstr(cpuTypesPkg::haltWord);

    r[0] = 32'h0;
    r[1] = 32'h0000_1234;
    r[2] = r[1] + signExt(16'hFFFD);
    r[3] = r[1] + r[2];
    r[4] = r[2] - r[3];
    r[5] = r[4] & r[3];
    r[6] = r[5] | r[1];
    r[7] = r[6] ^ r[4];
    r[8] = ($signed(r[4]) < $signed(r[1])) ? 32'd1 : 32'd0;
    r[9] = ($signed(r[1]) < $signed(r[4])) ? 32'd1 : 32'd0;
    r[10] = r[8] << 5;
    r[11] = r[10] | 32'h0000_8001;  // zero extended
    r[12] = r[4] & 32'h0000_F0F0;
    r[13] = 32'hBEEF_0000;
    r[14] = r[13] + signExt(16'h7FFF);

    runProgram(randomMode ? 600 : 200);
    for (k = 1; k < 15; k++) begin
      checkStored('h100 + 4 * k, r[k]);
    end
    randomWaits = 1'b0;
    finishTest();
  endtask

  task automatic loadUseTest();
    cpuTypesPkg::wordT sum;
    startTest("load-use");
    clearProgram();
    clearData();
    dmem[8'h80] = 32'h1357_2468;  // byte address 0x200
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 1, 'h200));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 2, 'h11));
    addInstr(iInstr(cpuTypesPkg::LW, 1, 3, 0));
    addInstr(rInstr(cpuTypesPkg::ADDU, 3, 2, 4, 0));  // uses the load at once
    addInstr(iInstr(cpuTypesPkg::SW, 0, 4, 'h300));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 0, 'h55));
    addInstr(rInstr(cpuTypesPkg::ADDU, 0, 2, 5, 0));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 0, 'h304));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 5, 'h308));
    addInstr(iInstr(cpuTypesPkg::LW, 0, 6, 'h300));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 6, 'h30C));
    addInstr(cpuTypesPkg::haltWord);
    sum = 32'h1357_2468 + 32'h0000_0011;
    runProgram(200);
    checkStored('h300, sum);
    checkStored('h304, 32'h0);    // r0 ignores writes
    checkStored('h308, 32'h0000_0011);
    checkStored('h30C, sum);
    finishTest();
  endtask

  // branches and jumps, flushed slots write r10 or r11
  task automatic controlFlowTest();
    int jalAddr;
    startTest("control flow");
    clearProgram();
    clearData();
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 1, 5));     // 0
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 2, 5));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 3, 7));
    addInstr(iInstr(cpuTypesPkg::BEQ, 1, 2, 2));       // 3, taken to 6
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 10, 'h111));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 11, 'h222));
    addInstr(iInstr(cpuTypesPkg::BEQ, 1, 3, 1));       // 6, falls through
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 12, 'h333));
    addInstr(iInstr(cpuTypesPkg::BNE, 1, 3, 2));       // 8, taken to 11
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 10, 'h444));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 11, 'h555));
    addInstr(iInstr(cpuTypesPkg::BNE, 1, 2, 1));       // 11, falls through
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 13, 'h666));
    addInstr(jInstr(cpuTypesPkg::J, 16));              // 13
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 10, 'h777));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 11, 'h888));
    addInstr(jInstr(cpuTypesPkg::JAL, 20));            // 16, links 68
    addInstr(jInstr(cpuTypesPkg::J, 24));              // 17, return point
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 10, 'hAAA));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 11, 'hBBB));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 14, 'h999)); // 20, subroutine
    addInstr(rInstr(cpuTypesPkg::JR, 31, 0, 0, 0));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 10, 'hCCC));
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 11, 'hDDD));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 10, 'h100));   // 24
    addInstr(iInstr(cpuTypesPkg::SW, 0, 11, 'h104));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 12, 'h108));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 13, 'h10C));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 14, 'h110));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 31, 'h114));
    addInstr(cpuTypesPkg::haltWord);
    jalAddr = 16 * 4;
    runProgram(300);
    checkStored('h100, 32'h0);
    checkStored('h104, 32'h0);
    checkStored('h108, 32'h0000_0333);
    checkStored('h10C, 32'h0000_0666);
    checkStored('h110, 32'h0000_0999);
    checkStored('h114, cpuTypesPkg::wordT'(jalAddr + 4));
    finishTest();
  endtask

  task automatic haltTest();
    startTest("halt");
    clearProgram();
    clearData();
    addInstr(iInstr(cpuTypesPkg::ADDIU, 0, 1, 'h42));
    addInstr(iInstr(cpuTypesPkg::SW, 0, 1, 'h100));
    addInstr(cpuTypesPkg::haltWord);
    addInstr(iInstr(cpuTypesPkg::SW, 0, 1, 'h104));   // younger than halt
    addInstr(iInstr(cpuTypesPkg::SW, 0, 1, 'h108));
    runProgram(100);
    checkWord("store count", 32'd1, cpuTypesPkg::wordT'(storeCount));
    repeat (20) begin
      @(negedge CLK);
      checkBit("halt", 1'b1, halt);
    end
    checkWord("store count", 32'd1, cpuTypesPkg::wordT'(storeCount));
    checkStored('h100, 32'h0000_0042);
    checkStored('h104, fillWord('h104 >> 2));
    checkStored('h108, fillWord('h108 >> 2));
    finishTest();
  endtask

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    imemload = '0;
    ihit = 1'b1;                  // fetch always hits
    dmemload = '0;
    dhit = 1'b0;
    randomWaits = 1'b0;
    accessBusy = 1'b0;
    waitLeft = 0;
    storeCount = 0;
    rngState = 32'd89;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;

    resetTest();
    aluChainTest("alu chain", 1'b0);
    loadUseTest();
    controlFlowTest();
    aluChainTest("data back-pressure", 1'b1);
    haltTest();

    $display("tests run %0d, tests failed %0d, check errors %0d",
             testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/aluUnit.sv
/* combinational ALU, seven operations and zero flag */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
  input cpuTypesPkg::aluOpT aluOp,
  input cpuTypesPkg::wordT portA,
  input cpuTypesPkg::wordT portB,
  output cpuTypesPkg::wordT outputPort,
  output logic zero
);

  always_comb begin
    case (aluOp)
      cpuTypesPkg::aluAdd: outputPort = portA + portB;
      cpuTypesPkg::aluSub: outputPort = portA - portB;
      cpuTypesPkg::aluAnd: outputPort = portA & portB;
      cpuTypesPkg::aluOr:  outputPort = portA | portB;
      cpuTypesPkg::aluXor: outputPort = portA ^ portB;
      cpuTypesPkg::aluSlt: outputPort = {31'b0, $signed(portA) < $signed(portB)};
      cpuTypesPkg::aluSll: outputPort = portB << portA[4:0];  // amount on port A
      default:             outputPort = '0;
    endcase
  end

  // equality test for beq and bne after a subtract
  assign zero = (outputPort == '0);

endmodule

`default_nettype wire

//--- hdl/controlIf.sv
/* decoded control bits, decoder to datapath */
`timescale 1ns/1ns
`default_nettype none

interface controlIf;
  logic regDst;                 // rd instead of rt
  logic aluSrc;                 // immediate on port B
  logic regWen;
  logic dRen;
  logic dWen;
  logic branch;
  logic bne;                    // branch on not equal
  logic jmp;
  logic jl;                     // link into r31
  logic jmpReg;
  logic lui;
  logic zeroExt;
  logic shiftSel;               // shamt on port A
  cpuTypesPkg::aluOpT aluOp;

  modport cu (
    output regDst, aluSrc, regWen, dRen, dWen, branch, bne,
    output jmp, jl, jmpReg, lui, zeroExt, shiftSel, aluOp
  );

  modport dp (
    input regDst, aluSrc, regWen, dRen, dWen, branch, bne,
    input jmp, jl, jmpReg, lui, zeroExt, shiftSel, aluOp
  );
endinterface

`default_nettype wire

//--- hdl/controlUnit.sv
/* instruction decoder, opcode and function to control bits */
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
  input cpuTypesPkg::wordT instr,
  controlIf.cu cuif
);
  cpuTypesPkg::opcodeT opcode;
  cpuTypesPkg::functT funct;

  assign opcode = cpuTypesPkg::opcodeT'(instr[31:26]);
  assign funct = cpuTypesPkg::functT'(instr[5:0]);

  always_comb begin
    cuif.regDst = 1'b0;
    cuif.aluSrc = 1'b0;
    cuif.regWen = 1'b0;
    cuif.dRen = 1'b0;
    cuif.dWen = 1'b0;
    cuif.branch = 1'b0;
    cuif.bne = 1'b0;
    cuif.jmp = 1'b0;
    cuif.jl = 1'b0;
    cuif.jmpReg = 1'b0;
    cuif.lui = 1'b0;
    cuif.zeroExt = 1'b0;
    cuif.shiftSel = 1'b0;
    cuif.aluOp = cpuTypesPkg::aluAdd;
    case (opcode)
      cpuTypesPkg::RTYPE: begin
        cuif.regDst = 1'b1;
        cuif.regWen = 1'b1;
        case (funct)
          cpuTypesPkg::ADDU: cuif.aluOp = cpuTypesPkg::aluAdd;
          cpuTypesPkg::SUBU: cuif.aluOp = cpuTypesPkg::aluSub;
          cpuTypesPkg::AND:  cuif.aluOp = cpuTypesPkg::aluAnd;
          cpuTypesPkg::OR:   cuif.aluOp = cpuTypesPkg::aluOr;
          cpuTypesPkg::XOR:  cuif.aluOp = cpuTypesPkg::aluXor;
          cpuTypesPkg::SLT:  cuif.aluOp = cpuTypesPkg::aluSlt;
          cpuTypesPkg::SLL: begin
            cuif.shiftSel = 1'b1;
            cuif.aluOp = cpuTypesPkg::aluSll;
          end
          cpuTypesPkg::JR: begin
            cuif.jmpReg = 1'b1;
            cuif.regWen = 1'b0;
          end
          default: cuif.regWen = 1'b0;  // unsupported function
        endcase
      end
      cpuTypesPkg::ADDIU: begin
        cuif.aluSrc = 1'b1;
        cuif.regWen = 1'b1;
      end
      cpuTypesPkg::ANDI: begin
        cuif.aluSrc = 1'b1;
        cuif.zeroExt = 1'b1;
        cuif.regWen = 1'b1;
        cuif.aluOp = cpuTypesPkg::aluAnd;
      end
      cpuTypesPkg::ORI: begin
        cuif.aluSrc = 1'b1;
        cuif.zeroExt = 1'b1;
        cuif.regWen = 1'b1;
        cuif.aluOp = cpuTypesPkg::aluOr;
      end
      cpuTypesPkg::LUI: begin
        cuif.lui = 1'b1;
        cuif.regWen = 1'b1;
      end
      cpuTypesPkg::LW: begin
        cuif.aluSrc = 1'b1;
        cuif.regWen = 1'b1;
        cuif.dRen = 1'b1;
      end
      cpuTypesPkg::SW: begin
        cuif.aluSrc = 1'b1;
        cuif.dWen = 1'b1;
      end
      cpuTypesPkg::BEQ: begin
        cuif.branch = 1'b1;
        cuif.aluOp = cpuTypesPkg::aluSub;
      end
      cpuTypesPkg::BNE: begin
        cuif.branch = 1'b1;
        cuif.bne = 1'b1;
        cuif.aluOp = cpuTypesPkg::aluSub;
      end
      cpuTypesPkg::J: cuif.jmp = 1'b1;
      cpuTypesPkg::JAL: begin
        cuif.jmp = 1'b1;
        cuif.jl = 1'b1;
        cuif.regWen = 1'b1;
      end
      default: ;  // halt word and unknown opcodes pass as no-ops
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/cpuTypesPkg.sv
/* shared processor types: word and register index widths,
   opcode, function and ALU operation encodings, halt word */
`default_nettype none

package cpuTypesPkg;

  typedef logic [31:0] wordT;   // data or address word
  typedef logic [4:0] regIdxT;  // register index

  // major opcodes, MIPS encoding
  typedef enum logic [5:0] {
    RTYPE  = 6'b000000,
    J      = 6'b000010,
    JAL    = 6'b000011,
    BEQ    = 6'b000100,
    BNE    = 6'b000101,
    ADDIU  = 6'b001001,
    ANDI   = 6'b001100,
    ORI    = 6'b001101,
    LUI    = 6'b001111,
    LW     = 6'b100011,
    SW     = 6'b101011,
    HALTOP = 6'b111111   // top bits of the halt word
  } opcodeT;

  // function field of register ops
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    SLT  = 6'b101010
  } functT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSll
  } aluOpT;

  localparam wordT haltWord = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- hdl/datapath.sv
/* pipelined datapath: PC, IF/ID, ID/EX, EX/MEM and MEM/WB registers,
   operand and write-back muxes, data memory drive and halt */
`timescale 1ns/1ns
`default_nettype none

module datapath #(
  parameter cpuTypesPkg::wordT pcInit = '0
) (
  input logic CLK,
  input logic nRST,
  datapathCacheIf.dp dpif
);
  registerFileIf rfif ();
  controlIf cuif ();

  logic advance, memPending, halted;
  logic stallPc, ifidFreeze, ifidFlush, idexFlush, takeBranch;
  cpuTypesPkg::wordT pc, pc4, nextPc;

  cpuTypesPkg::wordT ifidInstr, ifidPc4;
  cpuTypesPkg::regIdxT idRs, idRt, idDest;

  cpuTypesPkg::wordT idexInstr, idexPc4, idexRdat1, idexRdat2;
  cpuTypesPkg::regIdxT idexDest, exRs, exRt;
  logic idexRegWen, idexDRen, idexDWen, idexAluSrc, idexBranch, idexBne, idexJmp;
  logic idexJl, idexJmpReg, idexLui, idexZeroExt, idexShiftSel, idexHalt;
  cpuTypesPkg::aluOpT idexAluOp;

  cpuTypesPkg::wordT extImm, rsVal, rtVal, fwdA, fwdB, portA, portB, aluOut, exResult;
  logic selA, selB, aluZero;

  cpuTypesPkg::wordT exmemResult, exmemStore;
  cpuTypesPkg::regIdxT exmemDest;
  logic exmemRegWen, exmemDRen, exmemDWen, exmemHalt;

  cpuTypesPkg::wordT memwbResult, memwbLoad, wbValue;
  cpuTypesPkg::regIdxT memwbDest;
  logic memwbRegWen, memwbDRen, memwbHalt;

  registerFile u_registerFile (.CLK, .nRST, .rfif(rfif));
  controlUnit u_controlUnit (.instr(ifidInstr), .cuif(cuif));
  aluUnit u_aluUnit (.aluOp(idexAluOp), .portA, .portB, .outputPort(aluOut), .zero(aluZero));
  hazardUnit u_hazardUnit (
    .idexDRen, .idexDest, .rs(idRs), .rt(idRt), .takeBranch,
    .stallPc, .ifidFreeze, .ifidFlush, .idexFlush
  );
  forwardingUnit u_forwardingUnit (
    .rs(exRs), .rt(exRt),
    .exmemWen(exmemRegWen), .exmemDest, .exmemValue(exmemResult),
    .memwbWen(memwbRegWen), .memwbDest, .memwbValue(wbValue),
    .fwdA, .fwdB, .selA, .selB
  );

  // whole pipeline waits while a data access is out
  assign halted = dpif.halt | memwbHalt;
  assign memPending = dpif.dmemREN | dpif.dmemWEN;
  assign advance = dpif.ihit & ~memPending & ~halted;

  assign pc4 = pc + 32'd4;
  assign dpif.imemaddr = pc;
  assign dpif.imemREN = ~dpif.halt;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= pcInit;
    end else if (advance && !stallPc) begin
      pc <= nextPc;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ifidInstr <= '0;
    end else if (advance && ifidFlush) begin
      ifidInstr <= '0;          // sll r0, a nop
    end else if (advance && !ifidFreeze) begin
      ifidInstr <= dpif.imemload;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance && !ifidFreeze) begin
      ifidPc4 <= pc4;
    end
  end

  assign idRs = ifidInstr[25:21];
  assign idRt = ifidInstr[20:16];
  assign rfif.rsel1 = idRs;
  assign rfif.rsel2 = idRt;
  assign idDest = cuif.jl ? 5'd31 : (cuif.regDst ? ifidInstr[15:11] : ifidInstr[20:16]);

  // bits that can change state are cleared by a flush
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      idexRegWen <= 1'b0;
      idexDRen <= 1'b0;
      idexDWen <= 1'b0;
      idexBranch <= 1'b0;
      idexJmp <= 1'b0;
      idexJmpReg <= 1'b0;
      idexHalt <= 1'b0;
      idexAluSrc <= 1'b0;
      idexBne <= 1'b0;
      idexJl <= 1'b0;
      idexLui <= 1'b0;
      idexZeroExt <= 1'b0;
      idexShiftSel <= 1'b0;
      idexAluOp <= cpuTypesPkg::aluAdd;
    end else if (advance) begin
      idexRegWen <= cuif.regWen & ~idexFlush;
      idexDRen <= cuif.dRen & ~idexFlush;
      idexDWen <= cuif.dWen & ~idexFlush;
      idexBranch <= cuif.branch & ~idexFlush;
      idexJmp <= cuif.jmp & ~idexFlush;
      idexJmpReg <= cuif.jmpReg & ~idexFlush;
      idexHalt <= (ifidInstr == cpuTypesPkg::haltWord) & ~idexFlush;
      idexAluSrc <= cuif.aluSrc;
      idexBne <= cuif.bne;
      idexJl <= cuif.jl;
      idexLui <= cuif.lui;
      idexZeroExt <= cuif.zeroExt;
      idexShiftSel <= cuif.shiftSel;
      idexAluOp <= cuif.aluOp;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      idexInstr <= ifidInstr;
      idexPc4 <= ifidPc4;
      idexDest <= idDest;
      idexRdat1 <= rfif.rdat1;
      idexRdat2 <= rfif.rdat2;
    end else begin
      // frozen, hold resolved operands as the MEM/WB producer may retire
      idexRdat1 <= rsVal;
      idexRdat2 <= rtVal;
    end
  end

  assign exRs = idexInstr[25:21];
  assign exRt = idexInstr[20:16];
  assign extImm = idexZeroExt ? {16'b0, idexInstr[15:0]} : {{16{idexInstr[15]}}, idexInstr[15:0]};
  assign rsVal = selA ? fwdA : idexRdat1;
  assign rtVal = selB ? fwdB : idexRdat2;
  assign portA = idexShiftSel ? {27'b0, idexInstr[10:6]} : rsVal;
  assign portB = idexAluSrc ? extImm : rtVal;

  // lui upper half, jal link, else ALU
  assign exResult = idexLui ? {idexInstr[15:0], 16'b0} : (idexJl ? idexPc4 : aluOut);

  assign takeBranch = (idexBranch & (aluZero ^ idexBne)) | idexJmp | idexJmpReg;

  always_comb begin
    if (idexJmpReg) begin
      nextPc = rsVal;
    end else if (idexJmp) begin
      nextPc = {idexPc4[31:28], idexInstr[25:0], 2'b00};
    end else if (takeBranch) begin
      nextPc = idexPc4 + {extImm[29:0], 2'b00};
    end else begin
      nextPc = pc4;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exmemRegWen <= 1'b0;
      exmemDRen <= 1'b0;
      exmemDWen <= 1'b0;
      exmemHalt <= 1'b0;
    end else if (dpif.dhit) begin
      exmemRegWen <= 1'b0;      // access done, slot becomes a bubble
      exmemDRen <= 1'b0;
      exmemDWen <= 1'b0;
      exmemHalt <= 1'b0;
    end else if (advance) begin
      exmemRegWen <= idexRegWen;
      exmemDRen <= idexDRen;
      exmemDWen <= idexDWen;
      exmemHalt <= idexHalt;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      exmemResult <= exResult;
      exmemStore <= rtVal;
      exmemDest <= idexDest;
    end
  end

  // nothing younger than the halt word reaches memory
  assign dpif.dmemREN = exmemDRen & ~halted;
  assign dpif.dmemWEN = exmemDWen & ~halted;
  assign dpif.dmemaddr = exmemResult;
  assign dpif.dmemstore = exmemStore;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      memwbRegWen <= 1'b0;
      memwbDRen <= 1'b0;
      memwbHalt <= 1'b0;
    end else if (advance || dpif.dhit) begin
      memwbRegWen <= exmemRegWen;
      memwbDRen <= exmemDRen;
      memwbHalt <= exmemHalt;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance || dpif.dhit) begin
      memwbResult <= exmemResult;
      memwbLoad <= dpif.dmemload;
      memwbDest <= exmemDest;
    end
  end

  assign wbValue = memwbDRen ? memwbLoad : memwbResult;
  assign rfif.wen = memwbRegWen;
  assign rfif.wsel = memwbDest;
  assign rfif.wdat = wbValue;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      dpif.halt <= 1'b0;
    end else if (memwbHalt) begin
      dpif.halt <= 1'b1;        // sticky
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    !(dpif.dmemREN && dpif.dmemWEN));

endmodule

`default_nettype wire

//--- hdl/datapathCacheIf.sv
/* datapath to memory-port interface, fetch and data sides plus halt */
`timescale 1ns/1ns
`default_nettype none

interface datapathCacheIf;
  logic imemREN;
  cpuTypesPkg::wordT imemaddr;
  cpuTypesPkg::wordT imemload;
  logic ihit;                   // fetch done
  logic dmemREN;                // levels, held until dhit
  logic dmemWEN;
  cpuTypesPkg::wordT dmemaddr;
  cpuTypesPkg::wordT dmemstore;
  cpuTypesPkg::wordT dmemload;
  logic dhit;                   // data access done
  logic halt;

  modport dp (
    output imemREN, imemaddr, dmemREN, dmemWEN, dmemaddr, dmemstore, halt,
    input imemload, ihit, dmemload, dhit
  );

  modport mem (
    input imemREN, imemaddr, dmemREN, dmemWEN, dmemaddr, dmemstore, halt,
    output imemload, ihit, dmemload, dhit
  );
endinterface

`default_nettype wire

//--- hdl/forwardingUnit.sv
/* execute operand forwarding from EX/MEM and MEM/WB */
`timescale 1ns/1ns
`default_nettype none

module forwardingUnit (
  input cpuTypesPkg::regIdxT rs,
  input cpuTypesPkg::regIdxT rt,
  input logic exmemWen,
  input cpuTypesPkg::regIdxT exmemDest,
  input cpuTypesPkg::wordT exmemValue,
  input logic memwbWen,
  input cpuTypesPkg::regIdxT memwbDest,
  input cpuTypesPkg::wordT memwbValue,
  output cpuTypesPkg::wordT fwdA,
  output cpuTypesPkg::wordT fwdB,
  output logic selA,
  output logic selB
);
  logic exA, exB, wbA, wbB;

  assign exA = exmemWen && (exmemDest != '0) && (exmemDest == rs);
  assign exB = exmemWen && (exmemDest != '0) && (exmemDest == rt);
  assign wbA = memwbWen && (memwbDest != '0) && (memwbDest == rs);
  assign wbB = memwbWen && (memwbDest != '0) && (memwbDest == rt);

  // younger producer wins
  assign fwdA = exA ? exmemValue : memwbValue;
  assign fwdB = exB ? exmemValue : memwbValue;
  assign selA = exA | wbA;
  assign selB = exB | wbB;

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
/* load-use stall and taken branch or jump flush */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
  input logic idexDRen,
  input cpuTypesPkg::regIdxT idexDest,
  input cpuTypesPkg::regIdxT rs,
  input cpuTypesPkg::regIdxT rt,
  input logic takeBranch,
  output logic stallPc,
  output logic ifidFreeze,
  output logic ifidFlush,
  output logic idexFlush
);
  logic loadUse;

  // load in EX feeding the instruction in ID
  assign loadUse = idexDRen && (idexDest != '0) && (idexDest == rs || idexDest == rt);

  always_comb begin
    stallPc = 1'b0;
    ifidFreeze = 1'b0;
    ifidFlush = 1'b0;
    idexFlush = 1'b0;
    if (takeBranch) begin
      ifidFlush = 1'b1;         // both wrong-path slots
      idexFlush = 1'b1;
    end else if (loadUse) begin
      stallPc = 1'b1;
      ifidFreeze = 1'b1;
      idexFlush = 1'b1;         // one bubble
    end
  end

  always_comb begin
    assert (!(stallPc && ifidFlush))
      else $error("hazard: PC stall with IF/ID flush");
  end

endmodule

`default_nettype wire

//--- hdl/pipeCpu.sv
/* processor top, datapath behind plain memory ports */
`timescale 1ns/1ns
`default_nettype none

module pipeCpu #(
  parameter cpuTypesPkg::wordT pcInit = '0
) (
  input logic CLK,
  input logic nRST,
  output logic imemREN,
  output cpuTypesPkg::wordT imemaddr,
  input cpuTypesPkg::wordT imemload,
  input logic ihit,
  output logic dmemREN,
  output logic dmemWEN,
  output cpuTypesPkg::wordT dmemaddr,
  output cpuTypesPkg::wordT dmemstore,
  input cpuTypesPkg::wordT dmemload,
  input logic dhit,
  output logic halt
);
  datapathCacheIf dcif ();

  datapath #(.pcInit(pcInit)) u_datapath (.CLK, .nRST, .dpif(dcif));

  // memory side of the interface
  assign imemREN = dcif.imemREN;
  assign imemaddr = dcif.imemaddr;
  assign dcif.imemload = imemload;
  assign dcif.ihit = ihit;
  assign dmemREN = dcif.dmemREN;
  assign dmemWEN = dcif.dmemWEN;
  assign dmemaddr = dcif.dmemaddr;
  assign dmemstore = dcif.dmemstore;
  assign dcif.dmemload = dmemload;
  assign dcif.dhit = dhit;
  assign halt = dcif.halt;

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
/* 32 x 32 register file, r0 hardwired, write bypass to reads */
`timescale 1ns/1ns
`default_nettype none

module registerFile (
  input logic CLK,
  input logic nRST,
  registerFileIf.rf rfif
);
  cpuTypesPkg::wordT regs [32];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rfif.wen && rfif.wsel != '0) begin
      regs[rfif.wsel] <= rfif.wdat;   // r0 never written
    end
  end

  // same-cycle write shows on the read ports
  always_comb begin
    rfif.rdat1 = regs[rfif.rsel1];
    rfif.rdat2 = regs[rfif.rsel2];
    if (rfif.wen && rfif.wsel != '0 && rfif.wsel == rfif.rsel1) begin
      rfif.rdat1 = rfif.wdat;
    end
    if (rfif.wen && rfif.wsel != '0 && rfif.wsel == rfif.rsel2) begin
      rfif.rdat2 = rfif.wdat;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    (rfif.rsel1 == '0) |-> (rfif.rdat1 == '0));
  assert property (@(posedge CLK) disable iff (!nRST)
    (rfif.rsel2 == '0) |-> (rfif.rdat2 == '0));

endmodule

`default_nettype wire

//--- hdl/registerFileIf.sv
/* register file ports, two reads and one write */
`timescale 1ns/1ns
`default_nettype none

interface registerFileIf;
  cpuTypesPkg::regIdxT rsel1;
  cpuTypesPkg::regIdxT rsel2;
  cpuTypesPkg::wordT rdat1;
  cpuTypesPkg::wordT rdat2;
  logic wen;
  cpuTypesPkg::regIdxT wsel;
  cpuTypesPkg::wordT wdat;

  modport rf (
    input rsel1, rsel2, wen, wsel, wdat,
    output rdat1, rdat2
  );

  modport dp (
    output rsel1, rsel2, wen, wsel, wdat,
    input rdat1, rdat2
  );
endinterface

`default_nettype wire

//--- pipeCpu.f
hdl/cpuTypesPkg.sv
hdl/datapathCacheIf.sv
hdl/controlIf.sv
hdl/registerFileIf.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/controlUnit.sv
hdl/hazardUnit.sv
hdl/forwardingUnit.sv
hdl/datapath.sv
hdl/pipeCpu.sv
bench/pipeCpuTb.sv
